// File: verilog.f
verilog/pad_pkg.sv
verilog/bridge_settings_regs.sv
verilog/player_port_select.sv
verilog/pad_output_stage.sv
verilog/pad_router_top.sv
verif/tb_pad_router.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_pad_router
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = TEST PASSED

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass or fail comes from the log search
run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_pad_router.sv
////////////////////////////////////////
// pad router testbench
// directed tests of the settings bank,
// port routing, six-button mask and reset
////////////////////////////////////////

`timescale 1ns/1ps

module tb_pad_router
  import pad_pkg::*;
();

  localparam int unsigned hold_cycles = 32;
  localparam int wait_limit = 100;
  // key bits that reach the console pad even in two-button mode
  localparam pad_keys_t used_keys = 16'hC03F;

  logic         clk_74a;
  logic         pll_core_locked;
  bridge_addr_t bridge_addr;
  logic         bridge_wr;
  bridge_data_t bridge_wr_data;
  bridge_data_t bridge_rd_data;
  pad_keys_t    pocket_keys [num_players];
  pad_keys_t    snac_keys [num_players];
  pce_pad_t     pads [num_players];
  logic         core_reset;
  int           seed = 54;

  // adapter port per player for codes 0 to 6, 1-based, zero keeps the pocket key
  int assignment_table [7][4] = '{
    '{1, 0, 0, 0},
    '{0, 1, 0, 0},
    '{1, 2, 0, 0},
    '{2, 1, 0, 0},
    '{1, 2, 3, 4},
    '{4, 3, 2, 1},
    '{0, 0, 1, 2}
  };

  pad_router_top #(.RESET_HOLD_CYCLES(hold_cycles)) DUT (.*);

  always #50 clk_74a = ~clk_74a;

  ////////////////////////////////////////
  // checks and expected values
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("error at %0t: %s", $time, reason);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic compare_pad(input pce_pad_t got, input pce_pad_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "pad compare");
    end
  endtask

  task automatic compare_word(input bridge_data_t got, input bridge_data_t exp,
                              input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "word compare");
    end
  endtask

  // face keys to buttons 1-4, shoulders to 5-6
  function automatic pce_pad_t expected_pad(input pad_keys_t keys, input logic six_en);
    pce_pad_t p;
    p = '0;
    p.up       = keys[0];
    p.down     = keys[1];
    p.left     = keys[2];
    p.right    = keys[3];
    p.button_1 = keys[4];
    p.button_2 = keys[5];
    p.select   = keys[14];
    p.start    = keys[15];
    if (six_en) begin
      p.button_3 = keys[6];
      p.button_4 = keys[7];
      p.button_5 = keys[8];
      p.button_6 = keys[9];
    end
    return p;
  endfunction

  function automatic pad_keys_t expected_keys(input int player, input logic [3:0] code,
                                              input logic adapter_on);
    int adapter;
    adapter = 0;
    if (adapter_on && code < 4'd7) begin
      adapter = assignment_table[code[2:0]][player];
    end
    if (adapter == 0) begin
      return pocket_keys[player];
    end
    return snac_keys[adapter - 1];
  endfunction

  ////////////////////////////////////////
  // bus and key drivers
  ////////////////////////////////////////

  task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
    @(negedge clk_74a);
    bridge_addr = addr;
    bridge_wr = 1'b1;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
  endtask

  task automatic check_read(input bridge_addr_t addr, input bridge_data_t exp,
                            input string what);
    @(negedge clk_74a);
    bridge_addr = addr;
    #25;
    compare_word(bridge_rd_data, exp, what);
  endtask

  // eight words that differ in the bits the pads show
  task automatic drive_random_keys();
    pad_keys_t pool [2*num_players];
    pad_keys_t cand;
    bit        clash;
    int        tries;
    for (int n = 0; n < 2 * num_players; n++) begin
      clash = 1'b1;
      tries = 0;
      while (clash) begin
        if (tries == wait_limit) begin
          abort_run("no distinct random key word found");
        end
        cand = pad_keys_t'($random(seed));
        clash = 1'b0;
        for (int m = 0; m < n; m++) begin
          if ((pool[m] & used_keys) == (cand & used_keys)) begin
            clash = 1'b1;
          end
        end
        tries++;
      end
      pool[n] = cand;
    end
    @(negedge clk_74a);
    for (int i = 0; i < num_players; i++) begin
      pocket_keys[i] = pool[i];
      snac_keys[i] = pool[num_players + i];
    end
  endtask

  // selector edge, output stage edge, then sample
  task automatic check_all_pads(input logic [3:0] code, input logic adapter_on,
                                input logic six_en);
    repeat (2) @(negedge clk_74a);
    for (int i = 0; i < num_players; i++) begin
      compare_pad(pads[i], expected_pad(expected_keys(i, code, adapter_on), six_en),
                  $sformatf("code %0d player %0d", code, i + 1));
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset_defaults();
    for (int i = 0; i < num_players; i++) begin
      compare_pad(pads[i], '0, $sformatf("reset pad %0d", i + 1));
    end
    compare_word(bridge_data_t'(core_reset), '0, "core_reset after reset");
    check_read(addr_analog_settings, '0, "settings after reset");
  endtask

  task automatic test_settings_readback();
    bridge_data_t data;
    bridge_write(addr_analog_settings, 32'hFFFF_ABCD);
    check_read(addr_analog_settings, 32'h0000_2BCD, "upper bits dropped");
    bridge_write(addr_analog_settings, 32'h0000_0020);
    check_read(addr_analog_settings, 32'h0000_0020, "spare bit");
    bridge_write(addr_analog_settings, 32'h0000_3C00);
    check_read(addr_analog_settings, 32'h0000_3C00, "video_type");
    data = bridge_data_t'($random(seed));
    bridge_write(addr_analog_settings, data);
    check_read(addr_analog_settings, {18'd0, data[13:0]}, "random word");
    bridge_write(addr_button6, 32'h1);
    check_read(addr_button6, '0, "button6 address");
    check_read(addr_core_reset, '0, "core reset address");
    check_read(32'hF700_0004, '0, "unmapped address");
    bridge_write(addr_button6, 32'h0);
  endtask

  // adapter off, code 4 must not take effect
  task automatic test_pass_through();
    bridge_write(addr_analog_settings, {18'd0, 4'd0, 4'd4, 1'b0, 5'd0});
    repeat (6) begin
      drive_random_keys();
      check_all_pads(4'd4, 1'b0, 1'b0);
    end
    bridge_write(addr_button6, 32'h1);
    repeat (6) begin
      drive_random_keys();
      check_all_pads(4'd4, 1'b0, 1'b1);
    end
  endtask

  task automatic test_assignment_table();
    for (int c = 0; c < 16; c++) begin
      bridge_write(addr_analog_settings, {18'd0, 4'(c), 4'(c), 1'b0, 5'(c + 1)});
      repeat (4) begin
        drive_random_keys();
        check_all_pads(4'(c), 1'b1, 1'b1);
      end
    end
  endtask

  task automatic test_core_reset_stretch();
    int high;
    bridge_write(addr_core_reset, 32'h1);
    compare_word(bridge_data_t'(core_reset), 32'h1, "core_reset after request");
    high = 0;
    while (core_reset) begin
      if (high > wait_limit) begin
        abort_run("core_reset stuck high");
      end
      high++;
      @(negedge clk_74a);
    end
    compare_word(bridge_data_t'(high), bridge_data_t'(hold_cycles), "core_reset length");
    repeat (2 * hold_cycles) begin
      @(negedge clk_74a);
      compare_word(bridge_data_t'(core_reset), '0, "core_reset after hold");
    end
  endtask

  initial begin
    clk_74a = 1'b0;
    pll_core_locked = 1'b0;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    for (int i = 0; i < num_players; i++) begin
      pocket_keys[i] = '0;
      snac_keys[i] = '0;
    end
    repeat (16) @(negedge clk_74a);
    pll_core_locked = 1'b1;
    test_reset_defaults();
    test_settings_readback();
    test_pass_through();
    test_assignment_table();
    test_core_reset_stretch();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: verilog/pad_router_top.sv
////////////////////////////////////////
// pad router top level
// settings bank, four port selectors and
// the console pad output stage
////////////////////////////////////////

`timescale 1ns/1ps

module pad_router_top
  import pad_pkg::*;
#(
  parameter int unsigned RESET_HOLD_CYCLES = 1048576
) (
  input  logic         clk_74a,
  input  logic         pll_core_locked,
  // host bridge, synchronous to clk_74a
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  output bridge_data_t bridge_rd_data,
  // handheld and adapter key words
  input  pad_keys_t    pocket_keys [num_players],
  input  pad_keys_t    snac_keys [num_players],
  output pce_pad_t     pads [num_players],
  output logic         core_reset
);

  core_settings_t settings;
  pad_keys_t      routed [num_players];

  bridge_settings_regs #(
    .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
  ) u_settings (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings),
    .core_reset     (core_reset)
  );

  ////////////////////////////////////////
  // one selector per player port
  ////////////////////////////////////////

  for (genvar i = 0; i < num_players; i++) begin : g_port
    player_port_select #(
      .PORT_INDEX(i)
    ) u_select (
      .clk_74a        (clk_74a),
      .pll_core_locked(pll_core_locked),
      .settings       (settings.analog),
      .pocket_key     (pocket_keys[i]),
      .snac_keys      (snac_keys),
      .routed_keys    (routed[i])
    );
  end

  pad_output_stage u_output (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .button6_enable (settings.button6_enable),
    .routed         (routed),
    .pads           (pads)
  );

endmodule

// File: verilog/pad_output_stage.sv
////////////////////////////////////////
// pad output stage
// key bitmaps to console buttons with
// six-button masking, one register stage
////////////////////////////////////////

`timescale 1ns/1ps

module pad_output_stage
  import pad_pkg::*;
(
  input  logic      clk_74a,
  input  logic      pll_core_locked,
  input  logic      button6_enable,
  input  pad_keys_t routed [num_players],
  output pce_pad_t  pads [num_players]
);

  // buttons 3 to 6 exist only on the six-button pad
  function automatic pce_pad_t map_keys(input pad_keys_t keys, input logic six_en);
    pce_pad_t pad;
    pad.button_1 = keys[key_bit_a];
    pad.button_2 = keys[key_bit_b];
    pad.button_3 = keys[key_bit_x] & six_en;
    pad.button_4 = keys[key_bit_y] & six_en;
    pad.button_5 = keys[key_bit_l1] & six_en;
    pad.button_6 = keys[key_bit_r1] & six_en;
    pad.select   = keys[key_bit_select];
    pad.start    = keys[key_bit_start];
    pad.up       = keys[key_bit_up];
    pad.down     = keys[key_bit_down];
    pad.left     = keys[key_bit_left];
    pad.right    = keys[key_bit_right];
    return pad;
  endfunction

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      for (int i = 0; i < num_players; i++) begin
        pads[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_players; i++) begin
        pads[i] <= map_keys(routed[i], button6_enable);
      end
    end
  end

  for (genvar g = 0; g < num_players; g++) begin : g_mask_check
    six_button_masked: assert property (
      @(posedge clk_74a) disable iff (!pll_core_locked)
      !button6_enable |=> {pads[g].button_3, pads[g].button_4,
                           pads[g].button_5, pads[g].button_6} == 4'b0000
    );
  end

endmodule

// File: verilog/player_port_select.sv
////////////////////////////////////////
// player port source select
// picks the handheld keys or one adapter
// port per the assignment code, registered
////////////////////////////////////////

`timescale 1ns/1ps

module player_port_select
  import pad_pkg::*;
#(
  parameter int PORT_INDEX = 0
) (
  input  logic             clk_74a,
  input  logic             pll_core_locked,
  input  analog_settings_t settings,
  input  pad_keys_t        pocket_key,
  input  pad_keys_t        snac_keys [num_players],
  output pad_keys_t        routed_keys
);

  // adapter port feeding this player in reversed order
  localparam int mirror_index = num_players - 1 - PORT_INDEX;

  pad_keys_t next_keys;

  // players the table does not name keep their own keys
  always_comb begin
    next_keys = pocket_key;
    if (settings.game_cont_type != '0) begin
      case (settings.cont_assignment)
        4'd0: begin
          if (PORT_INDEX == 0) next_keys = snac_keys[0];
        end
        4'd1: begin
          if (PORT_INDEX == 1) next_keys = snac_keys[0];
        end
        4'd2: begin
          if (PORT_INDEX == 0) next_keys = snac_keys[0];
          if (PORT_INDEX == 1) next_keys = snac_keys[1];
        end
        // first two players swapped
        4'd3: begin
          if (PORT_INDEX == 0) next_keys = snac_keys[1];
          if (PORT_INDEX == 1) next_keys = snac_keys[0];
        end
        4'd4: next_keys = snac_keys[PORT_INDEX];
        4'd5: next_keys = snac_keys[mirror_index];
        // adapter on the multitap ports only
        4'd6: begin
          if (PORT_INDEX == 2) next_keys = snac_keys[0];
          if (PORT_INDEX == 3) next_keys = snac_keys[1];
        end
        default: next_keys = pocket_key;
      endcase
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      routed_keys <= '0;
    end else begin
      routed_keys <= next_keys;
    end
  end

  // catches undriven key inputs at the top
  routed_keys_known: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !$isunknown(routed_keys)
  );

endmodule

// File: verilog/bridge_settings_regs.sv
////////////////////////////////////////
// bridge settings bank
// decodes host writes into the core settings,
// returns the adapter word on read and
// stretches a requested core reset
////////////////////////////////////////

`timescale 1ns/1ps

module bridge_settings_regs
  import pad_pkg::*;
#(
  parameter int unsigned RESET_HOLD_CYCLES = 1048576
) (
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  bridge_addr_t   bridge_addr,
  input  logic           bridge_wr,
  input  bridge_data_t   bridge_wr_data,
  output bridge_data_t   bridge_rd_data,
  output core_settings_t settings,
  output logic           core_reset
);

  localparam int unsigned hold_width = $clog2(RESET_HOLD_CYCLES + 1);

  // cycles of core reset still to go
  logic [hold_width-1:0] hold_count;

  ////////////////////////////////////////
  // write decode
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        addr_analog_settings: begin
          settings.analog <= analog_settings_t'(bridge_wr_data[13:0]);
        end
        addr_button6: begin
          settings.button6_enable <= bridge_wr_data[0];
        end
        default: begin
          // other addresses belong to blocks outside this bank
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // core reset stretcher
  ////////////////////////////////////////

  // a new request restarts the full hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_count <= '0;
    end else if (bridge_wr && bridge_addr == addr_core_reset) begin
      hold_count <= hold_width'(RESET_HOLD_CYCLES);
    end else if (hold_count != '0) begin
      hold_count <= hold_count - 1'b1;
    end
  end

  assign core_reset = (hold_count != '0);

  // readback, only the adapter word is visible
  always_comb begin
    bridge_rd_data = '0;
    if (bridge_addr == addr_analog_settings) begin
      bridge_rd_data = bridge_data_t'(settings.analog);
    end
  end

  // count stays in range across reloads and decrements
  hold_count_in_range: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    hold_count <= hold_width'(RESET_HOLD_CYCLES)
  );

endmodule

// File: verilog/pad_pkg.sv
////////////////////////////////////////
// pad routing package
// bridge register map, settings word layout,
// key bitmap bits and console pad button set
////////////////////////////////////////

package pad_pkg;

  // player ports on the console side
  localparam int num_players = 4;

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  ////////////////////////////////////////
  // bridge register map
  ////////////////////////////////////////

  localparam bridge_addr_t addr_analog_settings = 32'hF700_0000;
  localparam bridge_addr_t addr_button6         = 32'h0000_0104;
  localparam bridge_addr_t addr_core_reset      = 32'h0000_0050;

  // adapter settings word, 14 bits as written by the host
  typedef struct packed {
    logic [3:0] video_type;
    logic [3:0] cont_assignment;
    logic       spare;
    // zero disables the adapter
    logic [4:0] game_cont_type;
  } analog_settings_t;

  typedef struct packed {
    analog_settings_t analog;
    logic             button6_enable;
  } core_settings_t;

  ////////////////////////////////////////
  // key bitmap from handheld or adapter
  ////////////////////////////////////////

  typedef logic [15:0] pad_keys_t;

  localparam int key_bit_up     = 0;
  localparam int key_bit_down   = 1;
  localparam int key_bit_left   = 2;
  localparam int key_bit_right  = 3;
  localparam int key_bit_a      = 4;
  localparam int key_bit_b      = 5;
  localparam int key_bit_x      = 6;
  localparam int key_bit_y      = 7;
  localparam int key_bit_l1     = 8;
  localparam int key_bit_r1     = 9;
  localparam int key_bit_select = 14;
  localparam int key_bit_start  = 15;

  // console pad, six buttons plus run/select and dpad
  typedef struct packed {
    logic button_1;
    logic button_2;
    logic button_3;
    logic button_4;
    logic button_5;
    logic button_6;
    logic select;
    logic start;
    logic up;
    logic down;
    logic left;
    logic right;
  } pce_pad_t;

endpackage
